// ==== hw/ip_tx_consts.svh ====
// header length, ip version and ihl, byte and word widths, header pointer width
`ifndef IP_TX_CONSTS_SVH
`define IP_TX_CONSTS_SVH

// fixed ipv4 header, no options
`define IP_HDR_BYTES 20
`define IP_VERSION 4
`define IP_IHL 5

// datapath widths
`define BYTE_W 8
`define WORD_W 16

// wide enough to index all header bytes
`define HDR_PTR_W 5

`endif

// ==== hw/ip_hdr_pkg.sv ====
// ipv4 header field types and the packed header struct
`include "ip_tx_consts.svh"

package ip_hdr_pkg;

    // one stream byte
    typedef logic [`BYTE_W-1:0] byte_t;

    // 16-bit header word or checksum
    typedef logic [`WORD_W-1:0] csum_t;

    typedef logic [31:0] ip_addr_t;

    // header fields supplied by the user
    // version, ihl and checksum are filled in by the framer
    typedef struct packed {
        logic [5:0]          dscp;
        logic [1:0]          ecn;
        logic [`WORD_W-1:0]  length;
        logic [`WORD_W-1:0]  identification;
        logic [2:0]          flags;
        logic [12:0]         fragment_offset;
        logic [`BYTE_W-1:0]  ttl;
        logic [`BYTE_W-1:0]  protocol;
        ip_addr_t            source_ip;
        ip_addr_t            dest_ip;
    } ip_hdr_t;

endpackage

// ==== hw/ip_tx_pkg.sv ====
// transmitter control types: fsm state enum and header pointer type
`include "ip_tx_consts.svh"

package ip_tx_pkg;

    // index of the header byte being sent
    typedef logic [`HDR_PTR_W-1:0] hdr_ptr_t;

    // frame sequencing
    typedef enum logic [1:0] {
        idle               = 2'd0,
        write_header       = 2'd1,
        write_payload      = 2'd2,
        write_payload_last = 2'd3
    } tx_state_e;

endpackage

// ==== hw/byte_stream_if.sv ====
// byte stream interface with valid, ready, last and user, plus source and sink modports
`timescale 1ns/1ps

interface byte_stream_if;
    import ip_hdr_pkg::*;

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;
    // marks a bad byte
    logic  user;

    modport source (output data, output valid, output last, output user, input ready);

    modport sink (input data, input valid, input last, input user, output ready);

endinterface

// ==== hw/ip_hdr_checksum.sv ====
// one's-complement accumulator of 16-bit ipv4 header words
`timescale 1ns/1ps
`include "ip_tx_consts.svh"

module ip_hdr_checksum (
    input  logic              clk,
    input  logic              csum_load,
    input  logic              csum_add,
    input  ip_hdr_pkg::csum_t csum_word,
    output ip_hdr_pkg::csum_t csum_sum
);
    import ip_hdr_pkg::*;

    csum_t            sum_reg;
    logic [`WORD_W:0] raw_sum;

    // plain sum with the carry kept in the top bit
    assign raw_sum = {1'b0, sum_reg} + {1'b0, csum_word};

    always_ff @(posedge clk) begin
        if (csum_load) begin
            sum_reg <= csum_word;
        end else if (csum_add) begin
            // end-around carry, cannot overflow again
            sum_reg <= raw_sum[`WORD_W-1:0] + csum_t'(raw_sum[`WORD_W]);
        end
    end

    // running sum, complemented by the fsm when sent
    assign csum_sum = sum_reg;

endmodule

// ==== hw/ip_tx_fsm.sv ====
// ipv4 tx control: header capture, header byte sequencing, payload length and error tracking
`timescale 1ns/1ps
`include "ip_tx_consts.svh"

module ip_tx_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                hdr_valid,
    output logic                hdr_ready,
    input  ip_hdr_pkg::ip_hdr_t hdr,
    input  ip_hdr_pkg::byte_t   in_data,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic                in_last,
    input  logic                in_user,
    byte_stream_if.source       out,
    output logic                csum_load,
    output logic                csum_add,
    output ip_hdr_pkg::csum_t   csum_word,
    input  ip_hdr_pkg::csum_t   csum_sum,
    output logic                busy,
    output logic                error_early_term
);
    import ip_hdr_pkg::*;
    import ip_tx_pkg::*;

    localparam logic [3:0]         ip_version   = `IP_VERSION;
    localparam logic [3:0]         ip_ihl       = `IP_IHL;
    localparam logic [`WORD_W-1:0] hdr_len      = `IP_HDR_BYTES;
    localparam hdr_ptr_t           last_hdr_ptr = `IP_HDR_BYTES - 1;

    tx_state_e                         state;
    tx_state_e                         state_next;
    hdr_ptr_t                          hdr_ptr;
    hdr_ptr_t                          hdr_ptr_next;
    logic [`WORD_W-1:0]                pay_count;
    logic [`WORD_W-1:0]                pay_count_next;
    ip_hdr_t                           hdr_reg;
    byte_t                             last_data;
    logic [`IP_HDR_BYTES*`BYTE_W-1:0]  hdr_flat;
    byte_t                             hdr_byte;
    logic                              word_load;
    logic                              word_add;
    logic                              store_hdr;
    logic                              store_last;
    logic                              in_ready_reg;
    logic                              in_ready_next;
    logic                              error_next;

    // payload only moves when the buffer can take the byte it produces
    assign in_ready = in_ready_reg && out.ready;

    // wire order of the header, first byte in the top bits
    assign hdr_flat = {ip_version, ip_ihl, hdr_reg.dscp, hdr_reg.ecn, hdr_reg.length,
                       hdr_reg.identification, hdr_reg.flags, hdr_reg.fragment_offset,
                       hdr_reg.ttl, hdr_reg.protocol, ~csum_sum,
                       hdr_reg.source_ip, hdr_reg.dest_ip};
    assign hdr_byte = hdr_flat[(last_hdr_ptr - hdr_ptr) * `BYTE_W +: `BYTE_W];

    // checksum words, summed while bytes 1 to 9 go out
    assign word_load = (hdr_ptr == 5'd1);
    assign word_add  = (hdr_ptr >= 5'd2) && (hdr_ptr <= 5'd9);

    always_comb begin
        case (hdr_ptr)
            5'd1:    csum_word = {ip_version, ip_ihl, hdr_reg.dscp, hdr_reg.ecn};
            5'd2:    csum_word = hdr_reg.length;
            5'd3:    csum_word = hdr_reg.identification;
            5'd4:    csum_word = {hdr_reg.flags, hdr_reg.fragment_offset};
            5'd5:    csum_word = {hdr_reg.ttl, hdr_reg.protocol};
            5'd6:    csum_word = hdr_reg.source_ip[31:16];
            5'd7:    csum_word = hdr_reg.source_ip[15:0];
            5'd8:    csum_word = hdr_reg.dest_ip[31:16];
            5'd9:    csum_word = hdr_reg.dest_ip[15:0];
            default: csum_word = '0;
        endcase
    end

    always_comb begin
        state_next     = state;
        hdr_ptr_next   = hdr_ptr;
        pay_count_next = pay_count;
        in_ready_next  = in_ready_reg;
        store_hdr      = 1'b0;
        store_last     = 1'b0;
        error_next     = 1'b0;
        csum_load      = 1'b0;
        csum_add       = 1'b0;
        out.valid      = 1'b0;
        out.data       = hdr_byte;
        out.last       = 1'b0;
        out.user       = 1'b0;

        case (state)
            idle: begin
                hdr_ptr_next = '0;
                if (hdr_valid && hdr_ready) begin
                    store_hdr      = 1'b1;
                    pay_count_next = hdr.length - hdr_len;
                    state_next     = write_header;
                end
            end
            write_header: begin
                // one header byte on every cycle the buffer is ready
                out.valid = out.ready;
                if (out.ready) begin
                    hdr_ptr_next = hdr_ptr + 1'b1;
                    csum_load    = word_load;
                    csum_add     = word_add;
                    if (hdr_ptr == last_hdr_ptr) begin
                        in_ready_next = 1'b1;
                        state_next    = write_payload;
                    end
                end
            end
            write_payload: begin
                out.data = in_data;
                out.last = in_last;
                out.user = in_user;
                if (in_valid && in_ready) begin
                    pay_count_next = pay_count - 1'b1;
                    out.valid      = 1'b1;
                    if (in_last) begin
                        // frame ended short of the declared length
                        if (pay_count != 'd1) begin
                            out.user   = 1'b1;
                            error_next = 1'b1;
                        end
                        in_ready_next = 1'b0;
                        state_next    = idle;
                    end else if (pay_count == 'd1) begin
                        // keep the final byte until the input's last shows up
                        store_last = 1'b1;
                        out.valid  = 1'b0;
                        state_next = write_payload_last;
                    end
                end
            end
            write_payload_last: begin
                // excess input is dropped
                out.data = last_data;
                out.last = in_last;
                out.user = in_user;
                if (in_valid && in_ready && in_last) begin
                    out.valid     = 1'b1;
                    in_ready_next = 1'b0;
                    state_next    = idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= idle;
            hdr_ptr          <= '0;
            hdr_ready        <= 1'b0;
            in_ready_reg     <= 1'b0;
            busy             <= 1'b0;
            error_early_term <= 1'b0;
        end else begin
            state            <= state_next;
            hdr_ptr          <= hdr_ptr_next;
            hdr_ready        <= (state_next == idle);
            in_ready_reg     <= in_ready_next;
            busy             <= (state_next != idle);
            error_early_term <= error_next;
        end

        pay_count <= pay_count_next;
        if (store_hdr) begin
            hdr_reg <= hdr;
        end
        if (store_last) begin
            last_data <= in_data;
        end
    end

endmodule

// ==== hw/stream_out_buf.sv ====
// two-slot output register stage with registered ready toward the source
`timescale 1ns/1ps

module stream_out_buf (
    input  logic              clk,
    input  logic              rst,
    byte_stream_if.sink       in,
    output ip_hdr_pkg::byte_t out_data,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_last,
    output logic              out_user
);
    import ip_hdr_pkg::*;

    // spare slot
    byte_t temp_data;
    logic  temp_valid;
    logic  temp_last;
    logic  temp_user;

    logic  ready_early;
    logic  out_valid_next;
    logic  temp_valid_next;
    logic  store_in_to_out;
    logic  store_in_to_temp;
    logic  store_temp_to_out;

    // ready next cycle if the output drains or the spare slot cannot fill up
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in.valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in.ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next  = in.valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled so park the byte
                temp_valid_next  = in.valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in.ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            in.ready   <= ready_early;
        end

        if (store_in_to_out) begin
            out_data <= in.data;
            out_last <= in.last;
            out_user <= in.user;
        end else if (store_temp_to_out) begin
            out_data <= temp_data;
            out_last <= temp_last;
            out_user <= temp_user;
        end

        if (store_in_to_temp) begin
            temp_data <= in.data;
            temp_last <= in.last;
            temp_user <= in.user;
        end
    end

endmodule

// ==== hw/ip_eth_tx.sv ====
// ipv4 transmit framer top level: header and payload in, framed byte stream out
`timescale 1ns/1ps

module ip_eth_tx (
    input  logic                clk,
    input  logic                rst,
    // header handshake
    input  logic                hdr_valid,
    output logic                hdr_ready,
    input  ip_hdr_pkg::ip_hdr_t hdr,
    // payload in
    input  ip_hdr_pkg::byte_t   in_data,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic                in_last,
    input  logic                in_user,
    // ip packet out
    output ip_hdr_pkg::byte_t   out_data,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_last,
    output logic                out_user,
    output logic                busy,
    output logic                error_early_term
);
    import ip_hdr_pkg::*;

    logic  csum_load;
    logic  csum_add;
    csum_t csum_word;
    csum_t csum_sum;

    // fsm to output buffer
    byte_stream_if fsm_out ();

    ip_tx_fsm fsm_i (
        .clk              (clk),
        .rst              (rst),
        .hdr_valid        (hdr_valid),
        .hdr_ready        (hdr_ready),
        .hdr              (hdr),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_last          (in_last),
        .in_user          (in_user),
        .out              (fsm_out),
        .csum_load        (csum_load),
        .csum_add         (csum_add),
        .csum_word        (csum_word),
        .csum_sum         (csum_sum),
        .busy             (busy),
        .error_early_term (error_early_term)
    );

    ip_hdr_checksum csum_i (
        .clk       (clk),
        .csum_load (csum_load),
        .csum_add  (csum_add),
        .csum_word (csum_word),
        .csum_sum  (csum_sum)
    );

    stream_out_buf out_buf_i (
        .clk       (clk),
        .rst       (rst),
        .in        (fsm_out),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_user  (out_user)
    );

endmodule

// ==== tests/ip_eth_tx_tb.sv ====
// testbench for ip_eth_tx with clock, reset, stimulus, reference model, output compare and watchdog
`timescale 1ns/1ps
`include "ip_tx_consts.svh"

module ip_eth_tx_tb;
    import ip_hdr_pkg::*;
    import ip_tx_pkg::*;

    // declared payload length and bytes actually sent per frame
    localparam int num_frames = 8;
    localparam int decl_tab [num_frames] = '{12, 9, 16, 5, 30, 3, 10, 1};
    localparam int sent_tab [num_frames] = '{12, 15, 6, 5, 30, 8, 4, 1};

    logic    clk = 1'b0;
    logic    rst;
    logic    hdr_valid;
    logic    hdr_ready;
    ip_hdr_t hdr;
    byte_t   in_data;
    logic    in_valid;
    logic    in_ready;
    logic    in_last;
    logic    in_user;
    byte_t   out_data;
    logic    out_valid;
    logic    out_ready = 1'b1;
    logic    out_last;
    logic    out_user;
    logic    busy;
    logic    error_early_term;

    integer seed = 32'h7c81;
    integer ready_seed = 32'h7c81 ^ 32'h5a5a;
    logic   bp_on = 1'b0;

    // expected output, one entry per byte
    byte_t exp_data [$];
    logic  exp_last [$];
    logic  exp_user [$];

    byte_t pay_buf [0:63];
    csum_t rx_csum;
    csum_t exp_csum;
    int    frame_pos = 0;
    int    err_seen = 0;
    int    exp_err = 0;

    ip_eth_tx dut_i (
        .clk              (clk),
        .rst              (rst),
        .hdr_valid        (hdr_valid),
        .hdr_ready        (hdr_ready),
        .hdr              (hdr),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_last          (in_last),
        .in_user          (in_user),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_last         (out_last),
        .out_user         (out_user),
        .busy             (busy),
        .error_early_term (error_early_term)
    );

    always #50 clk = ~clk;

    // random sink back-pressure while enabled
    always @(posedge clk) begin
        #1;
        if (bp_on) begin
            out_ready = ($random(ready_seed) & 1) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input csum_t got, input csum_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // one's complement of the folded sum of all header words but the checksum word
    function automatic csum_t header_checksum(input logic [159:0] bits);
        logic [31:0] acc;
        int          w;
        acc = '0;
        for (w = 0; w < 10; w++) begin
            if (w != 5) begin
                acc = acc + {16'h0, bits[159 - 16*w -: 16]};
            end
        end
        acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        return ~acc[15:0];
    endfunction

    function automatic ip_hdr_t random_header(input int pay_len);
        logic [159:0] r;
        ip_hdr_t      h;
        r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        h = r[135:0];
        h.length = 16'(`IP_HDR_BYTES + pay_len);
        return h;
    endfunction

    // expected header bytes with checksum and the payload cut to the declared length
    function automatic void build_expected(input ip_hdr_t h, input int sent);
        logic [159:0] bits;
        int           decl;
        int           count;
        int           i;
        bits = {4'(`IP_VERSION), 4'(`IP_IHL), h.dscp, h.ecn, h.length, h.identification,
                h.flags, h.fragment_offset, h.ttl, h.protocol, 16'h0000,
                h.source_ip, h.dest_ip};
        bits[79:64] = header_checksum(bits);
        for (i = 0; i < `IP_HDR_BYTES; i++) begin
            exp_data.push_back(bits[159 - 8*i -: 8]);
            exp_last.push_back(1'b0);
            exp_user.push_back(1'b0);
        end
        decl = int'(h.length) - `IP_HDR_BYTES;
        count = (sent < decl) ? sent : decl;
        for (i = 0; i < count; i++) begin
            exp_data.push_back(pay_buf[i]);
            exp_last.push_back(i == count - 1);
            // a short frame marks its final byte bad
            exp_user.push_back((i == count - 1) && (sent < decl));
        end
    endfunction

    function automatic int expected_total();
        int f;
        int total;
        total = 0;
        for (f = 0; f < num_frames; f++) begin
            total += `IP_HDR_BYTES + ((sent_tab[f] < decl_tab[f]) ? sent_tab[f] : decl_tab[f]);
        end
        return total;
    endfunction

    // compare every output transfer at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (error_early_term) begin
                err_seen = err_seen + 1;
            end
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    stop_with_failure("output byte appeared when no byte was expected");
                end else begin
                    if (frame_pos == 10 || frame_pos == 11) begin
                        // checksum bytes are compared as one word
                        rx_csum  = {rx_csum[`BYTE_W-1:0], out_data};
                        exp_csum = {exp_csum[`BYTE_W-1:0], exp_data.pop_front()};
                        if (frame_pos == 11) begin
                            check_word("header checksum", rx_csum, exp_csum);
                        end
                    end else begin
                        check_byte("out_data", out_data, exp_data.pop_front());
                    end
                    check_flag("out_user", out_user, exp_user.pop_front());
                    frame_pos = frame_pos + 1;
                    if (exp_last[0]) begin
                        frame_pos = 0;
                    end
                    check_flag("out_last", out_last, exp_last.pop_front());
                end
            end
        end
    end

    task automatic drive_header(input ip_hdr_t h);
        logic accepted;
        hdr       = h;
        hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            // idle between frames
            check_flag("busy", busy, 1'b0);
            accepted = hdr_ready;
            @(posedge clk);
            #1;
        end while (!accepted);
        hdr_valid = 1'b0;
    endtask

    task automatic drive_byte(input byte_t d, input logic last);
        logic accepted;
        in_data  = d;
        in_last  = last;
        in_valid = 1'b1;
        do begin
            @(negedge clk);
            check_flag("busy", busy, 1'b1);
            accepted = in_ready;
            @(posedge clk);
            #1;
        end while (!accepted);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_frame(input int idx);
        ip_hdr_t h;
        int      i;
        h = random_header(decl_tab[idx]);
        for (i = 0; i < sent_tab[idx]; i++) begin
            pay_buf[i] = byte_t'($random(seed));
        end
        build_expected(h, sent_tab[idx]);
        if (sent_tab[idx] < decl_tab[idx]) begin
            exp_err = exp_err + 1;
        end
        drive_header(h);
        for (i = 0; i < sent_tab[idx]; i++) begin
            drive_byte(pay_buf[i], i == sent_tab[idx] - 1);
        end
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        longint    limit_cycles;
        tx_state_e stall_state;
        limit_cycles = expected_total() * 20 + 1000;
        #(limit_cycles * 100);
        stall_state = tx_state_e'(dut_i.fsm_i.state);
        stop_with_failure($sformatf("timeout: output stalled after %0d cycles, fsm in %s",
                                    limit_cycles, stall_state.name()));
    end

    initial begin
        int f;
        int i;
        int err_before;
        rst       = 1'b1;
        hdr_valid = 1'b0;
        hdr       = '0;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_user   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet outputs after reset and header ready soon after
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("error_early_term", error_early_term, 1'b0);
        for (i = 0; i < 5 && !hdr_ready; i++) begin
            @(negedge clk);
        end
        if (!hdr_ready) begin
            stop_with_failure("hdr_ready did not rise after reset");
        end
        @(posedge clk);
        #1;

        // exact, long and short frames one at a time with the sink always ready
        for (f = 0; f < 3; f++) begin
            err_before = err_seen;
            send_frame(f);
            wait_drain();
            check_flag("error_early_term", err_seen != err_before, sent_tab[f] < decl_tab[f]);
            if (err_seen - err_before > 1) begin
                stop_with_failure("more than one error_early_term pulse in one frame");
            end
        end

        // back-to-back frames under random back-pressure
        bp_on = 1'b1;
        for (f = 3; f < num_frames; f++) begin
            send_frame(f);
        end
        wait_drain();
        bp_on = 1'b0;
        repeat (10) @(negedge clk);

        if (err_seen != exp_err) begin
            stop_with_failure($sformatf("saw %0d error_early_term pulses, expected %0d",
                                        err_seen, exp_err));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/ip_hdr_pkg.sv
hw/ip_tx_pkg.sv
hw/byte_stream_if.sv
hw/ip_hdr_checksum.sv
hw/ip_tx_fsm.sv
hw/stream_out_buf.sv
hw/ip_eth_tx.sv
tests/ip_eth_tx_tb.sv

// ==== Bender.yml ====
package:
  name: ip_eth_tx

sources:
  - include_dirs:
      - hw
    files:
      - hw/ip_hdr_pkg.sv
      - hw/ip_tx_pkg.sv
      - hw/byte_stream_if.sv
      - hw/ip_hdr_checksum.sv
      - hw/ip_tx_fsm.sv
      - hw/stream_out_buf.sv
      - hw/ip_eth_tx.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/ip_eth_tx_tb.sv
